//--- hw/sys_cont_pkg.sv
package sys_cont_pkg;

  localparam int addr_w    = 32;
  localparam int sel_w     = 16;
  localparam int n_int     = 16;
  localparam int int_idx_w = 4;
  localparam int n_flush   = 7;

  //////////////////////////////
  // flush vector layout
  //////////////////////////////

  localparam int flush_fetch_b     = 0;
  localparam int flush_decode_0_b  = 1;
  localparam int flush_decode_1_b  = 2;
  localparam int flush_register_b  = 3;
  localparam int flush_address_b   = 4;
  localparam int flush_execute_b   = 5;
  localparam int flush_writeback_b = 6;

  // everything up to execute, writeback keeps retiring
  localparam logic [n_flush-1:0] flush_redirect = ~(n_flush'(1) << flush_writeback_b);

  // front of the pipe only, execute already drained by the halt
  localparam logic [n_flush-1:0] flush_return =
      (n_flush'(1) << flush_fetch_b) |
      (n_flush'(1) << flush_decode_0_b) |
      (n_flush'(1) << flush_decode_1_b) |
      (n_flush'(1) << flush_register_b) |
      (n_flush'(1) << flush_address_b);

  //////////////////////////////
  // sequencer state codes
  //////////////////////////////

  localparam logic [2:0] ret_idle       = 3'd0;
  localparam logic [2:0] ret_pop_eflags = 3'd1;
  localparam logic [2:0] ret_pop_cs     = 3'd2;
  localparam logic [2:0] ret_pop_eip    = 3'd3;

  localparam logic [2:0] svc_idle    = 3'd0;
  localparam logic [2:0] svc_req_lo  = 3'd1;
  localparam logic [2:0] svc_wait_lo = 3'd2;
  localparam logic [2:0] svc_req_hi  = 3'd3;
  localparam logic [2:0] svc_wait_hi = 3'd4;

endpackage

//--- hw/idt_pkg.sv
package idt_pkg;

  import sys_cont_pkg::*;

  // second gate word sits right after the first
  localparam logic [addr_w-1:0] gate_addr_offset = 32'd4;

  // fixed gate addresses, one per interrupt line
  localparam logic [addr_w-1:0] idt_table [n_int] = '{
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_f000, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000,
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_0100, 32'h0000_2068, 32'h0000_2070, 32'h0000_f000
  };

  // gate word, after byte order fix
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [sel_w-1:0] selector;
      logic [sel_w-1:0] offset;
    } pair;
  } gate_word_u;

  // memory is big endian, core is little endian
  function automatic logic [addr_w-1:0] byte_swap(input logic [addr_w-1:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

//--- hw/int_pending_latch.sv
`timescale 1ns/1ps

module int_pending_latch
  import sys_cont_pkg::*;
(
  input  logic                 or_int_vec,
  input  logic                 rst_n,
  input  logic [n_int-1:0]     int_vec,
  input  logic                 int_clear,
  output logic                 pending,
  output logic [int_idx_w-1:0] int_idx
);

  logic [n_int-1:0] vec_q;
  logic [n_int-1:0] clr_mask;

  assign clr_mask = int_clear ? (n_int'(1) << int_idx) : '0;

  // sticky, clear beats a fresh edge on the same line
  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      vec_q <= '0;
    end else begin
      vec_q <= (vec_q | int_vec) & ~clr_mask;
    end
  end

  assign pending = |vec_q;

  // lowest line wins
  always_comb begin
    int_idx = '0;
    for (int i = n_int - 1; i >= 0; i--) begin
      if (vec_q[i]) begin
        int_idx = int_idx_w'(i);
      end
    end
  end

  // service must only retire a line that is really pending
  a_clear_pending: assert property (
    @(posedge or_int_vec) disable iff (!rst_n)
    int_clear |-> vec_q[int_idx]
  );

endmodule

//--- hw/int_service_seq.sv
`timescale 1ns/1ps

module int_service_seq
  import sys_cont_pkg::*;
  import idt_pkg::*;
(
  input  logic                 or_int_vec,
  input  logic                 rst_n,
  input  logic                 pending,
  input  logic [int_idx_w-1:0] int_idx,
  input  logic                 hold_int,
  input  logic                 mem_ready,
  input  logic                 mem_dp_valid,
  input  logic [addr_w-1:0]    mem_dp_read_data,
  output logic                 mem_valid,
  output logic [addr_w-1:0]    mem_address,
  output logic                 mem_dp_ready,
  output logic                 int_clear,
  output logic                 int_redirect,
  output logic [addr_w-1:0]    int_target,
  output logic [sel_w-1:0]     int_cs
);

  logic [2:0]        state_q;
  logic              redirect_q;
  logic              start;
  logic [addr_w-1:0] gate_q;
  logic [sel_w-1:0]  offset_q;
  logic [sel_w-1:0]  sel_q;
  gate_word_u        rd_word;

  assign rd_word.raw = byte_swap(mem_dp_read_data);

  // redirect_q blocks a restart while the latch still shows the old line
  assign start = (state_q == svc_idle) && pending && !hold_int && !redirect_q;

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      state_q    <= svc_idle;
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= 1'b0;
      case (state_q)
        svc_idle:    if (start) state_q <= svc_req_lo;
        svc_req_lo:  if (mem_ready) state_q <= svc_wait_lo;
        svc_wait_lo: if (mem_dp_valid) state_q <= svc_req_hi;
        svc_req_hi:  if (mem_ready) state_q <= svc_wait_hi;
        svc_wait_hi: begin
          if (mem_dp_valid) begin
            state_q    <= svc_idle;
            redirect_q <= 1'b1;
          end
        end
        default:     state_q <= svc_idle;
      endcase
    end
  end

  //////////////////////////////
  // gate capture
  //////////////////////////////

  always_ff @(posedge or_int_vec) begin
    if (start) begin
      gate_q <= idt_table[int_idx];
    end
    // first word gives the handler offset
    if (state_q == svc_wait_lo && mem_dp_valid) begin
      offset_q <= rd_word.pair.offset;
    end
    // second word gives the code segment
    if (state_q == svc_wait_hi && mem_dp_valid) begin
      sel_q <= rd_word.pair.selector;
    end
  end

  assign mem_valid    = (state_q == svc_req_lo) || (state_q == svc_req_hi);
  assign mem_address  = (state_q == svc_req_hi) ? gate_q + gate_addr_offset : gate_q;
  assign mem_dp_ready = (state_q == svc_wait_lo) || (state_q == svc_wait_hi);

  assign int_redirect = redirect_q;
  assign int_clear    = redirect_q;
  assign int_target   = {{(addr_w - sel_w){1'b0}}, offset_q};
  assign int_cs       = sel_q;

  a_addr_stable: assert property (
    @(posedge or_int_vec) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_address)
  );

  a_one_phase: assert property (
    @(posedge or_int_vec) disable iff (!rst_n)
    !(mem_valid && mem_dp_ready)
  );

endmodule

//--- hw/iretd_seq.sv
`timescale 1ns/1ps

module iretd_seq
  import sys_cont_pkg::*;
(
  input  logic               or_int_vec,
  input  logic               rst_n,
  input  logic               iretd,
  input  logic               ret_far,
  input  logic               ret_near,
  input  logic               iretd_pop_valid,
  input  logic [addr_w-1:0]  iretd_pop_data,
  output logic               iretd_halt,
  output logic               ret_load_eflags,
  output logic               ret_load_cs,
  output logic               ret_load_eip,
  output logic               ret_fetch_load,
  output logic [addr_w-1:0]  ret_data,
  output logic [n_flush-1:0] ret_flush
);

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       pop_eip;

  // entry point depends on how much is on the stack
  always_comb begin
    state_d = state_q;
    case (state_q)
      ret_idle: begin
        if (iretd) begin
          state_d = ret_pop_eflags;
        end else if (ret_far) begin
          state_d = ret_pop_cs;
        end else if (ret_near) begin
          state_d = ret_pop_eip;
        end
      end
      ret_pop_eflags: if (iretd_pop_valid) state_d = ret_pop_cs;
      ret_pop_cs:     if (iretd_pop_valid) state_d = ret_pop_eip;
      ret_pop_eip:    if (iretd_pop_valid) state_d = ret_idle;
      default:        state_d = ret_idle;
    endcase
  end

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      state_q <= ret_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign pop_eip = iretd_pop_valid && (state_q == ret_pop_eip);

  assign ret_load_eflags = iretd_pop_valid && (state_q == ret_pop_eflags);
  assign ret_load_cs     = iretd_pop_valid && (state_q == ret_pop_cs);
  assign ret_load_eip    = pop_eip;
  assign ret_fetch_load  = pop_eip;
  assign ret_data        = iretd_pop_data;
  assign ret_flush       = pop_eip ? flush_return : '0;

  // front end stays frozen until the last pop
  assign iretd_halt = (state_q != ret_idle);

  a_no_overlap: assert property (
    @(posedge or_int_vec) disable iff (!rst_n)
    (state_q != ret_idle) |-> !(iretd || ret_far || ret_near)
  );

endmodule

//--- hw/redirect_merge.sv
`timescale 1ns/1ps

module redirect_merge
  import sys_cont_pkg::*;
(
  input  logic               or_int_vec,
  input  logic               rst_n,
  input  logic               int_redirect,
  input  logic [addr_w-1:0]  int_target,
  input  logic [sel_w-1:0]   int_cs,
  input  logic               ret_load_eflags,
  input  logic               ret_load_cs,
  input  logic               ret_load_eip,
  input  logic               ret_fetch_load,
  input  logic [addr_w-1:0]  ret_data,
  input  logic [n_flush-1:0] ret_flush,
  input  logic               jump_load,
  input  logic [addr_w-1:0]  jump_load_address,
  input  logic               jump_load_cs,
  input  logic [sel_w-1:0]   jump_cs,
  output logic               flush_fetch,
  output logic               flush_decode_0,
  output logic               flush_decode_1,
  output logic               flush_register,
  output logic               flush_address,
  output logic               flush_execute,
  output logic               flush_writeback,
  output logic               fetch_load,
  output logic [addr_w-1:0]  fetch_load_address,
  output logic               reg_load_cs,
  output logic [sel_w-1:0]   reg_cs,
  output logic               reg_load_eip,
  output logic [addr_w-1:0]  reg_eip,
  output logic               reg_load_eflags,
  output logic [addr_w-1:0]  reg_eflags
);

  logic               jump_q;
  logic               jump_cs_load_q;
  logic [addr_w-1:0]  jump_addr_q;
  logic [sel_w-1:0]   jump_cs_q;
  logic               jump_cs_en;
  logic [n_flush-1:0] flush_vec;

  //////////////////////////////
  // jump register
  //////////////////////////////

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      jump_q         <= 1'b0;
      jump_cs_load_q <= 1'b0;
    end else begin
      jump_q         <= jump_load;
      jump_cs_load_q <= jump_load && jump_load_cs;
    end
  end

  always_ff @(posedge or_int_vec) begin
    if (jump_load) begin
      jump_addr_q <= jump_load_address;
      jump_cs_q   <= jump_cs;
    end
  end

  assign jump_cs_en = jump_q && jump_cs_load_q;

  //////////////////////////////
  // accumulation
  //////////////////////////////

  assign flush_vec = (int_redirect ? flush_redirect : '0) | ret_flush |
                     (jump_q ? flush_redirect : '0);

  assign flush_fetch     = flush_vec[flush_fetch_b];
  assign flush_decode_0  = flush_vec[flush_decode_0_b];
  assign flush_decode_1  = flush_vec[flush_decode_1_b];
  assign flush_register  = flush_vec[flush_register_b];
  assign flush_address   = flush_vec[flush_address_b];
  assign flush_execute   = flush_vec[flush_execute_b];
  assign flush_writeback = flush_vec[flush_writeback_b];

  assign fetch_load      = int_redirect || ret_fetch_load || jump_q;
  assign reg_load_cs     = int_redirect || ret_load_cs || jump_cs_en;
  assign reg_load_eip    = ret_load_eip;
  assign reg_load_eflags = ret_load_eflags;

  // buses read zero when nobody drives them
  assign fetch_load_address = int_redirect   ? int_target  :
                              ret_fetch_load ? ret_data    :
                              jump_q         ? jump_addr_q : '0;

  assign reg_cs = int_redirect ? int_cs                :
                  ret_load_cs  ? ret_data[sel_w-1:0]   :
                  jump_cs_en   ? jump_cs_q             : '0;

  assign reg_eip    = ret_load_eip ? ret_data : '0;
  assign reg_eflags = ret_load_eflags ? ret_data : '0;

  // interrupt, return and jump never redirect fetch together
  a_one_source: assert property (
    @(posedge or_int_vec) disable iff (!rst_n)
    $onehot0({int_redirect, ret_fetch_load, jump_q})
  );

endmodule

//--- hw/sys_cont_top.sv
`timescale 1ns/1ps

module sys_cont_top
  import sys_cont_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst_n,
  input  logic [n_int-1:0]  int_vec,
  input  logic              hold_int,
  input  logic              mem_ready,
  input  logic              mem_dp_valid,
  input  logic [addr_w-1:0] mem_dp_read_data,
  input  logic              iretd,
  input  logic              ret_far,
  input  logic              ret_near,
  input  logic              iretd_pop_valid,
  input  logic [addr_w-1:0] iretd_pop_data,
  input  logic              jump_load,
  input  logic [addr_w-1:0] jump_load_address,
  input  logic              jump_load_cs,
  input  logic [sel_w-1:0]  jump_cs,
  output logic              pending_int,
  output logic              mem_valid,
  output logic [addr_w-1:0] mem_address,
  output logic              mem_dp_ready,
  output logic              iretd_halt,
  output logic              flush_fetch,
  output logic              flush_decode_0,
  output logic              flush_decode_1,
  output logic              flush_register,
  output logic              flush_address,
  output logic              flush_execute,
  output logic              flush_writeback,
  output logic              fetch_load,
  output logic [addr_w-1:0] fetch_load_address,
  output logic              reg_load_cs,
  output logic [sel_w-1:0]  reg_cs,
  output logic              reg_load_eip,
  output logic [addr_w-1:0] reg_eip,
  output logic              reg_load_eflags,
  output logic [addr_w-1:0] reg_eflags
);

  // latch <-> service handshake
  logic                 pending;
  logic [int_idx_w-1:0] int_idx;
  logic                 int_clear;

  // interrupt redirect
  logic                 int_redirect;
  logic [addr_w-1:0]    int_target;
  logic [sel_w-1:0]     int_cs;

  // return sequence loads
  logic                 ret_load_eflags;
  logic                 ret_load_cs;
  logic                 ret_load_eip;
  logic                 ret_fetch_load;
  logic [addr_w-1:0]    ret_data;
  logic [n_flush-1:0]   ret_flush;

  assign pending_int = pending;

  int_pending_latch u_pending (.*);

  int_service_seq u_service (.*);

  iretd_seq u_iretd (.*);

  redirect_merge u_merge (.*);

endmodule

//--- bench/tb_sys_cont_ref.svh
`ifndef TB_SYS_CONT_REF_SVH
`define TB_SYS_CONT_REF_SVH

// bit 0 is fetch, bit 6 is writeback
localparam logic [n_flush-1:0] redirect_flush = 7'b011_1111;
localparam logic [n_flush-1:0] return_flush   = 7'b001_1111;

// memory contents as the core should see them
function automatic logic [addr_w-1:0] mem_pattern(input logic [addr_w-1:0] a);
  return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
endfunction

// gate words sit big endian in memory
function automatic logic [addr_w-1:0] to_big_endian(input logic [addr_w-1:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic int expected_pick(input logic [n_int-1:0] vec);
  for (int i = 0; i < n_int; i++) begin
    if (vec[i]) begin
      return i;
    end
  end
  return -1;
endfunction

function automatic logic [addr_w-1:0] expected_target(input int idx);
  logic [addr_w-1:0] w;
  w = mem_pattern(idt_table[idx]);
  return {16'h0000, w[15:0]};
endfunction

function automatic logic [sel_w-1:0] expected_cs(input int idx);
  logic [addr_w-1:0] w;
  w = mem_pattern(idt_table[idx] + 32'd4);
  return w[31:16];
endfunction

// slot 0 eflags, 1 cs, 2 eip
function automatic load_event_t return_load(input int slot, input logic [addr_w-1:0] w);
  load_event_t ev;
  ev = '0;
  case (slot)
    0: begin
      ev.load_eflags = 1'b1;
      ev.eflags      = w;
    end
    1: begin
      ev.load_cs = 1'b1;
      ev.cs      = w[15:0];
    end
    default: begin
      ev.load_eip = 1'b1;
      ev.eip      = w;
      ev.fetch    = 1'b1;
      ev.addr     = w;
      ev.flush    = return_flush;
    end
  endcase
  return ev;
endfunction

//////////////////////////////
// typed compares
//////////////////////////////

task automatic check_addr(input string what, input logic [addr_w-1:0] got, exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_sel(input string what, input logic [sel_w-1:0] got, exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flush(input string what, input logic [n_flush-1:0] got, exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_bit(input string what, input logic got, exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

//--- bench/tb_sys_cont.sv
`timescale 1ns/1ps

module tb_sys_cont
  import sys_cont_pkg::*;
  import idt_pkg::*;
();

  localparam int clk_half  = 50;
  localparam int reset_cyc = 16;
  localparam int test_cyc  = 40;
  localparam int n_ret     = 6;
  localparam int n_jump    = 4;

  // lines 1 4 7 12 13 14, then 0 2 8 15, then 5 9 under hold
  localparam logic [n_int-1:0] burst_a    = 16'h7092;
  localparam logic [n_int-1:0] burst_b    = 16'h8105;
  localparam logic [n_int-1:0] hold_lines = 16'h0220;

  typedef struct packed {
    logic               fetch;
    logic [addr_w-1:0]  addr;
    logic               load_cs;
    logic [sel_w-1:0]   cs;
    logic               load_eip;
    logic [addr_w-1:0]  eip;
    logic               load_eflags;
    logic [addr_w-1:0]  eflags;
    logic [n_flush-1:0] flush;
  } load_event_t;

  logic              or_int_vec;
  logic              rst_n;
  logic [n_int-1:0]  int_vec;
  logic              hold_int;
  logic              mem_ready;
  logic              mem_dp_valid;
  logic [addr_w-1:0] mem_dp_read_data;
  logic              iretd;
  logic              ret_far;
  logic              ret_near;
  logic              iretd_pop_valid;
  logic [addr_w-1:0] iretd_pop_data;
  logic              jump_load;
  logic [addr_w-1:0] jump_load_address;
  logic              jump_load_cs;
  logic [sel_w-1:0]  jump_cs;
  logic              pending_int;
  logic              mem_valid;
  logic [addr_w-1:0] mem_address;
  logic              mem_dp_ready;
  logic              iretd_halt;
  logic              flush_fetch;
  logic              flush_decode_0;
  logic              flush_decode_1;
  logic              flush_register;
  logic              flush_address;
  logic              flush_execute;
  logic              flush_writeback;
  logic              fetch_load;
  logic [addr_w-1:0] fetch_load_address;
  logic              reg_load_cs;
  logic [sel_w-1:0]  reg_cs;
  logic              reg_load_eip;
  logic [addr_w-1:0] reg_eip;
  logic              reg_load_eflags;
  logic [addr_w-1:0] reg_eflags;

  int                seed = 62;
  int                value_errors = 0;
  int                protocol_errors = 0;
  logic              checking = 1'b0;
  logic              jump_due = 1'b0;
  int                pops_left = 0;
  load_event_t       ev_q[$];
  logic [addr_w-1:0] addr_q[$];

  `include "tb_sys_cont_ref.svh"

  sys_cont_top dut_i (.*);

  initial or_int_vec = 1'b0;
  always #(clk_half) or_int_vec = ~or_int_vec;

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [n_flush-1:0] flush_out();
    return {flush_writeback, flush_execute, flush_address, flush_register,
            flush_decode_1, flush_decode_0, flush_fetch};
  endfunction

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic expect_interrupts(input logic [n_int-1:0] lines);
    logic [n_int-1:0] left;
    load_event_t      ev;
    int               idx;
    left = lines;
    while (left != '0) begin
      idx = expected_pick(left);
      left[idx] = 1'b0;
      addr_q.push_back(idt_table[idx]);
      addr_q.push_back(idt_table[idx] + 32'd4);
      ev = '0;
      ev.fetch   = 1'b1;
      ev.addr    = expected_target(idx);
      ev.load_cs = 1'b1;
      ev.cs      = expected_cs(idx);
      ev.flush   = redirect_flush;
      ev_q.push_back(ev);
    end
  endtask

  task automatic wait_drained();
    while (ev_q.size() != 0) begin
      @(negedge or_int_vec);
    end
    repeat (2) @(negedge or_int_vec);
  endtask

  task automatic run_interrupts(input logic [n_int-1:0] lines, input logic hold);
    expect_interrupts(lines);
    @(posedge or_int_vec);
    hold_int <= hold;
    int_vec  <= lines;
    @(posedge or_int_vec);
    int_vec <= '0;
    @(negedge or_int_vec);
    check_bit("pending_int after raise", pending_int, 1'b1);
    if (hold) begin
      repeat (12) begin
        @(negedge or_int_vec);
        check_bit("mem_valid under hold_int", mem_valid, 1'b0);
      end
      @(posedge or_int_vec);
      hold_int <= 1'b0;
    end
    wait_drained();
    check_bit("pending_int after service", pending_int, 1'b0);
  endtask

  task automatic release_request();
    iretd    <= 1'b0;
    ret_far  <= 1'b0;
    ret_near <= 1'b0;
  endtask

  task automatic run_return(input int first_slot);
    logic [addr_w-1:0] w;
    @(posedge or_int_vec);
    iretd    <= (first_slot == 0);
    ret_far  <= (first_slot == 1);
    ret_near <= (first_slot == 2);
    for (int slot = first_slot; slot < 3; slot++) begin
      w = $random(seed);
      ev_q.push_back(return_load(slot, w));
      repeat (rand_below(3)) begin
        @(posedge or_int_vec);
        release_request();
        iretd_pop_valid <= 1'b0;
      end
      @(posedge or_int_vec);
      release_request();
      iretd_pop_valid <= 1'b1;
      iretd_pop_data  <= w;
    end
    @(posedge or_int_vec);
    iretd_pop_valid <= 1'b0;
    wait_drained();
  endtask

  task automatic run_jump(input logic with_cs);
    load_event_t      ev;
    logic [sel_w-1:0] cs;
    ev = '0;
    cs = $random(seed);
    ev.fetch   = 1'b1;
    ev.addr    = $random(seed);
    ev.load_cs = with_cs;
    ev.cs      = with_cs ? cs : '0;
    ev.flush   = redirect_flush;
    ev_q.push_back(ev);
    @(posedge or_int_vec);
    jump_load         <= 1'b1;
    jump_load_address <= ev.addr;
    jump_load_cs      <= with_cs;
    jump_cs           <= cs;
    @(posedge or_int_vec);
    jump_load <= 1'b0;
    wait_drained();
  endtask

  task automatic check_reset_state();
    check_bit("mem_valid", mem_valid, 1'b0);
    check_bit("mem_dp_ready", mem_dp_ready, 1'b0);
    check_bit("iretd_halt", iretd_halt, 1'b0);
    check_bit("pending_int", pending_int, 1'b0);
    check_bit("fetch_load", fetch_load, 1'b0);
    check_bit("reg_load_cs", reg_load_cs, 1'b0);
    check_bit("reg_load_eip", reg_load_eip, 1'b0);
    check_bit("reg_load_eflags", reg_load_eflags, 1'b0);
    check_flush("flushes", flush_out(), '0);
  endtask

  task automatic compare_event(input load_event_t ev);
    check_bit("fetch_load", fetch_load, ev.fetch);
    check_addr("fetch_load_address", fetch_load_address, ev.addr);
    check_bit("reg_load_cs", reg_load_cs, ev.load_cs);
    check_sel("reg_cs", reg_cs, ev.cs);
    check_bit("reg_load_eip", reg_load_eip, ev.load_eip);
    check_addr("reg_eip", reg_eip, ev.eip);
    check_bit("reg_load_eflags", reg_load_eflags, ev.load_eflags);
    check_addr("reg_eflags", reg_eflags, ev.eflags);
    check_flush("flushes", flush_out(), ev.flush);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : stimulus
    rst_n             = 1'b0;
    int_vec           = '0;
    hold_int          = 1'b0;
    mem_ready         = 1'b0;
    mem_dp_valid      = 1'b0;
    mem_dp_read_data  = '0;
    iretd             = 1'b0;
    ret_far           = 1'b0;
    ret_near          = 1'b0;
    iretd_pop_valid   = 1'b0;
    iretd_pop_data    = '0;
    jump_load         = 1'b0;
    jump_load_address = '0;
    jump_load_cs      = 1'b0;
    jump_cs           = '0;
    repeat (reset_cyc) @(posedge or_int_vec);
    rst_n <= 1'b1;
    @(negedge or_int_vec);
    check_reset_state();
    checking = 1'b1;
    run_interrupts(burst_a, 1'b0);
    run_interrupts(hold_lines, 1'b1);
    for (int i = 0; i < n_ret; i++) begin
      run_return(i % 3);
    end
    for (int i = 0; i < n_jump; i++) begin
      run_jump((i % 2) == 1);
    end
    run_interrupts(burst_b, 1'b0);
    repeat (4) @(negedge or_int_vec);
    if (ev_q.size() != 0 || addr_q.size() != 0) begin
      protocol_errors++;
      $display("%0t: expected loads or memory reads never happened", $time);
    end
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  //////////////////////////////
  // memory model
  //////////////////////////////

  // sample at the falling edge, answer on the rising edge
  initial begin : memory_model
    logic              take_req;
    logic              take_data;
    logic              req_seen;
    logic              data_seen;
    logic              data_owed;
    logic [addr_w-1:0] req_addr;
    logic [addr_w-1:0] held_addr;
    int                req_wait;
    int                data_wait;
    data_owed = 1'b0;
    held_addr = '0;
    req_wait  = rand_below(4);
    data_wait = 0;
    forever begin
      @(negedge or_int_vec);
      take_req  = mem_valid && mem_ready;
      take_data = mem_dp_ready && mem_dp_valid;
      req_seen  = mem_valid && !mem_ready;
      data_seen = mem_dp_ready && !mem_dp_valid && data_owed;
      req_addr  = mem_address;
      @(posedge or_int_vec);
      if (take_req) begin
        mem_ready <= 1'b0;
        held_addr = req_addr;
        data_owed = 1'b1;
        data_wait = rand_below(4);
        req_wait  = rand_below(4);
        if (addr_q.size() == 0) begin
          protocol_errors++;
          $display("%0t: memory read with no interrupt service expected", $time);
        end else begin
          check_addr("mem_address", req_addr, addr_q.pop_front());
        end
      end else if (req_seen) begin
        if (req_wait == 0) begin
          mem_ready <= 1'b1;
        end else begin
          req_wait--;
        end
      end
      if (take_data) begin
        mem_dp_valid <= 1'b0;
        data_owed = 1'b0;
      end else if (data_seen) begin
        if (data_wait == 0) begin
          mem_dp_valid     <= 1'b1;
          mem_dp_read_data <= to_big_endian(mem_pattern(held_addr));
        end else begin
          data_wait--;
        end
      end
    end
  end

  //////////////////////////////
  // compare
  //////////////////////////////

  always @(negedge or_int_vec) begin : compare
    load_event_t ev;
    logic        any_load;
    if (checking) begin
      any_load = fetch_load || reg_load_cs || reg_load_eip || reg_load_eflags;
      check_bit("iretd_halt", iretd_halt, pops_left != 0);
      if (jump_due && !fetch_load) begin
        protocol_errors++;
        $display("%0t: no fetch redirect one cycle after jump_load", $time);
      end
      if (iretd_pop_valid && pops_left != 0 &&
          !(reg_load_eflags || reg_load_cs || reg_load_eip)) begin
        protocol_errors++;
        $display("%0t: a return pop loaded no register", $time);
      end
      if (any_load && ev_q.size() == 0) begin
        protocol_errors++;
        $display("%0t: load strobe seen with nothing expected", $time);
      end else if (any_load) begin
        ev = ev_q.pop_front();
        compare_event(ev);
      end else begin
        check_flush("idle flushes", flush_out(), '0);
      end
      // track how many pops the running return still needs
      jump_due = jump_load;
      if (iretd) begin
        pops_left = 3;
      end else if (ret_far) begin
        pops_left = 2;
      end else if (ret_near) begin
        pops_left = 1;
      end else if (iretd_pop_valid && pops_left != 0) begin
        pops_left--;
      end
    end
  end

  initial begin : watchdog
    int n_tests;
    n_tests = 2 + $countones(burst_a) + $countones(burst_b) + $countones(hold_lines) +
              n_ret + n_jump;
    #((reset_cyc + n_tests * test_cyc) * 2 * clk_half);
    $display("watchdog: run did not finish within %0d cycles",
             reset_cyc + n_tests * test_cyc);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
+incdir+bench
hw/sys_cont_pkg.sv
hw/idt_pkg.sv
hw/int_pending_latch.sv
hw/int_service_seq.sv
hw/iretd_seq.sv
hw/redirect_merge.sv
hw/sys_cont_top.sv
bench/tb_sys_cont.sv

//--- Bender.yml
package:
  name: sys_cont

sources:
  - files:
      - hw/sys_cont_pkg.sv
      - hw/idt_pkg.sv
      - hw/int_pending_latch.sv
      - hw/int_service_seq.sv
      - hw/iretd_seq.sv
      - hw/redirect_merge.sv
      - hw/sys_cont_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_sys_cont.sv
